//--- Makefile
# build with Verilator, run, then read the result from sim.log
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_acq -f files.f
	-./obj_dir/Vtb_acq > sim.log 2>&1
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- acq_checker.sv
`default_nettype none

module acq_checker (
	input wire                             avalon_clk,
	input wire                             rst_n,
	input wire                             test_end,          // one-cycle pulse, test drained
	input wire                             mem_write,
	input wire acq_pkg::addr_t             mem_address,
	input wire acq_pkg::word_t             mem_writedata,
	input wire                             mem_waitrequest_n,
	input wire                             triggered,
	input wire acq_pkg::stamp_t            trigger_stamp,
	input wire                             capture_done,
	input wire [acq_pkg::num_channels-1:0] overflow
);
	import acq_pkg::*;

	localparam int model_depth = 2048;           // words kept per channel, ring test needs 1040

	word_t exp_mem [num_channels][model_depth];  // captured words in arrival order
	word_t part [num_channels];                  // word being filled per channel
	int    slot;                                 // next sample slot, shared by all channels
	int    prod [num_channels];                  // words completed
	int    cons [num_channels];                  // words matched against writes
	int    wr_cnt [num_channels];                // words written, also the ring index
	int    test_errors;
	int    error_count  = 0;
	int    tests_done   = 0;
	int    tests_failed = 0;

	task automatic report_error(input string msg);
		$display("%s", msg);
		test_errors++;
		error_count++;
	endtask

	task automatic clear_model();
		slot        = 0;
		test_errors = 0;
		for (int c = 0; c < num_channels; c++) begin
			prod[c]   = 0;
			cons[c]   = 0;
			wr_cnt[c] = 0;
		end
	endtask

	// sample 16w lands in the low bits of word w
	task automatic capture_samples();
		for (int c = 0; c < num_channels; c++) begin
			part[c][slot*sample_width +: sample_width] = tb_acq.samples[c];
			if (slot == samples_per_word - 1 && prod[c] < model_depth) begin
				exp_mem[c][prod[c]] = part[c];
				prod[c]++;
			end
		end
		slot = (slot + 1) % samples_per_word;
	endtask

	task automatic check_write();
		int    c;
		addr_t exp_addr;
		bit    hit;
		c        = int'(mem_address[region_bits+chan_bits-1:region_bits]);   // channel field
		exp_addr = (addr_t'(c) << region_bits) | addr_t'(wr_cnt[c] % (1 << region_bits));
		if (mem_address !== exp_addr)
			report_error($sformatf("FAIL mem_address ch%0d: expected %h got %h",
				c, exp_addr, mem_address));
		if (tb_acq.exp_words >= 0 && wr_cnt[c] >= tb_acq.exp_words)
			report_error($sformatf("channel %0d wrote a word past its post-trigger limit", c));
		if (cons[c] >= prod[c]) begin
			report_error($sformatf("channel %0d wrote a word before one was complete", c));
		end else if (tb_acq.exp_ovf != '0) begin
			hit = 1'b0;                                              // lost words are skipped
			while (!hit && cons[c] < prod[c]) begin
				if (exp_mem[c][cons[c]] === mem_writedata)
					hit = 1'b1;
				else
					cons[c]++;
			end
			if (hit)
				cons[c]++;
			else
				report_error($sformatf("channel %0d wrote data matching no captured word", c));
		end else begin
			if (mem_writedata !== exp_mem[c][cons[c]])
				report_error($sformatf("FAIL mem_writedata ch%0d: expected %h got %h",
					c, exp_mem[c][cons[c]], mem_writedata));
			cons[c]++;
		end
		wr_cnt[c]++;
	endtask

	task automatic check_end();
		logic exp_done;
		exp_done = tb_acq.exp_trig && ((tb_acq.cur_count / samples_per_word) > tb_acq.exp_words);
		if (triggered !== tb_acq.exp_trig)
			report_error($sformatf("FAIL triggered: expected %h got %h", tb_acq.exp_trig, triggered));
		if (tb_acq.exp_trig && trigger_stamp !== tb_acq.exp_stamp)
			report_error($sformatf("FAIL trigger_stamp: expected %h got %h",
				tb_acq.exp_stamp, trigger_stamp));
		if (capture_done !== exp_done)
			report_error($sformatf("FAIL capture_done: expected %h got %h", exp_done, capture_done));
		if (overflow !== tb_acq.exp_ovf)
			report_error($sformatf("FAIL overflow: expected %h got %h", tb_acq.exp_ovf, overflow));
		for (int c = 0; c < num_channels; c++) begin
			if (tb_acq.exp_words >= 0 && wr_cnt[c] != tb_acq.exp_words)
				report_error($sformatf("channel %0d wrote %0d words where %0d were expected",
					c, wr_cnt[c], tb_acq.exp_words));
		end
		$display("test %0d: %s, %0d errors", tb_acq.test_num,
			(test_errors == 0) ? "passed" : "failed", test_errors);
		tests_done++;
		if (test_errors != 0)
			tests_failed++;
	endtask

	//////////////////////////////
	// per cycle monitor
	//////////////////////////////
	always @(posedge avalon_clk) begin
		if (!rst_n) begin
			clear_model();                                         // new test starts clean
		end else begin
			if (tb_acq.sample_valid)
				capture_samples();
			if (mem_write && mem_waitrequest_n)
				check_write();                                     // write completes this edge
			if (test_end)
				check_end();
		end
	end

endmodule

`default_nettype wire

//--- acq_golden.txt
# test threshold(hex) samples spike_index spike_chan spacing stall_mask(hex) trig stamp(hex) words ovf(hex)
# spike_index -1 sends no spike, words -1 leaves the per channel count unchecked
# stall_mask bit i drives mem_waitrequest_n on cycles where cycle % 8 == i, only while samples flow
1 7fff   128 -1 0 4 ff 0 0000    8 00
2 7fff   160 40 5 2 ff 1 0028    7 00
3 3fff 16640 -1 0 1 ff 0 0000 1040 00
4 7fff   256 -1 0 3 b6 0 0000   16 00
5 7fff    64 -1 0 1 00 0 0000   -1 ff

//--- acq_pkg.sv
`default_nettype none

package acq_pkg;

	//////////////////////////////
	// sample and word geometry
	//////////////////////////////
	localparam int num_channels     = 8;                              // front-end channels
	localparam int sample_width     = 16;                             // bits per sample
	localparam int samples_per_word = 16;                             // samples in one memory word
	localparam int word_width       = sample_width * samples_per_word; // 256 bit memory word
	localparam int chan_bits        = $clog2(num_channels);           // channel index width

	localparam int stamp_width      = 16;                             // sample time stamp counter

	//////////////////////////////
	// memory address layout
	//////////////////////////////
	localparam int region_bits      = 10;                             // ring index per channel
	localparam int addr_width       = 25;                             // word address on the bus

	// words each channel still writes after the trigger word
	localparam int post_trigger_words = 4;

	typedef logic [sample_width-1:0] sample_t;
	typedef logic [word_width-1:0]   word_t;
	typedef logic [addr_width-1:0]   addr_t;
	typedef logic [stamp_width-1:0]  stamp_t;
	typedef logic [chan_bits-1:0]    chan_t;

	// ring index field, channel field sits right above it
	localparam addr_t region_mask = addr_t'((1 << region_bits) - 1);

endpackage

`default_nettype wire

//--- acq_sva.sv
`default_nettype none

module acq_sva (
	input wire                             avalon_clk,
	input wire                             rst_n,
	input wire [acq_pkg::num_channels-1:0] word_ready,
	input wire [acq_pkg::num_channels-1:0] rd_request,
	input wire                             mem_write,
	input wire acq_pkg::addr_t             mem_address,
	input wire acq_pkg::word_t             mem_writedata,
	input wire                             mem_waitrequest_n
);

	//////////////////////////////
	// write port and pop rules
	//////////////////////////////
	write_held: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		mem_write && !mem_waitrequest_n |=>
		mem_write && $stable(mem_address) && $stable(mem_writedata))   // stalled write frozen
		else $error("write dropped or changed while the memory stalled");

	pop_when_ready: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		(rd_request & ~word_ready) == '0)                             // pop only a filled queue
		else $error("rd_request raised on a channel without word_ready");

	single_pop: assert property (@(posedge avalon_clk) disable iff (!rst_n)
		$onehot0(rd_request))                                         // one channel per grant
		else $error("more than one rd_request high in one cycle");

endmodule

bind dram_write_ctrl acq_sva sva_inst (
	.avalon_clk        (avalon_clk),
	.rst_n             (rst_n),
	.word_ready        (word_ready),
	.rd_request        (rd_request),
	.mem_write         (mem_write),
	.mem_address       (mem_address),
	.mem_writedata     (mem_writedata),
	.mem_waitrequest_n (mem_waitrequest_n)
);

`default_nettype wire

//--- acq_top.sv
`default_nettype none

module acq_top (
	input  wire                                            avalon_clk,
	input  wire                                            rst_n,
	input  wire                                            sample_valid,
	input  wire acq_pkg::sample_t [acq_pkg::num_channels-1:0] samples,   // channel 0 in low bits
	input  wire acq_pkg::sample_t                          threshold,
	input  wire                                            mem_waitrequest_n,
	output wire                                            mem_write,
	output wire acq_pkg::addr_t                            mem_address,
	output wire acq_pkg::word_t                            mem_writedata,
	output wire                                            triggered,
	output wire acq_pkg::stamp_t                           trigger_stamp,
	output wire                                            capture_done,
	output wire [acq_pkg::num_channels-1:0]                overflow       // one sticky bit per channel
);
	import acq_pkg::*;

	wire [num_channels-1:0]    word_ready;   // queue levels to the writer
	wire [num_channels-1:0]    rd_request;   // pops from the writer
	wire word_t [num_channels-1:0] word_data; // head of each queue

	//////////////////////////////
	// channel packers
	//////////////////////////////
	for (genvar ch = 0; ch < num_channels; ch++) begin : g_packer
		channel_packer packer_inst (
			.avalon_clk   (avalon_clk),
			.rst_n        (rst_n),
			.sample_valid (sample_valid),
			.sample       (samples[ch]),
			.word_ready   (word_ready[ch]),
			.word_data    (word_data[ch]),
			.rd_request   (rd_request[ch]),
			.overflow     (overflow[ch])
		);
	end

	// works beside the packers on the same samples
	trigger_detector trigger_inst (
		.avalon_clk    (avalon_clk),
		.rst_n         (rst_n),
		.sample_valid  (sample_valid),
		.samples       (samples),
		.threshold     (threshold),
		.triggered     (triggered),
		.trigger_stamp (trigger_stamp)
	);

	//////////////////////////////
	// memory writer
	//////////////////////////////
	dram_write_ctrl writer_inst (
		.avalon_clk        (avalon_clk),
		.rst_n             (rst_n),
		.word_ready        (word_ready),
		.word_data         (word_data),
		.rd_request        (rd_request),
		.triggered         (triggered),          // also a top output
		.trigger_stamp     (trigger_stamp),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata),
		.mem_waitrequest_n (mem_waitrequest_n),
		.capture_done      (capture_done)
	);

endmodule

`default_nettype wire

//--- channel_packer.sv
`default_nettype none

module channel_packer (
	input  wire                   avalon_clk,
	input  wire                   rst_n,
	input  wire                   sample_valid,   // shared strobe for all channels
	input  wire acq_pkg::sample_t sample,         // this channel's sample
	output logic                  word_ready,     // queue holds at least one word
	output acq_pkg::word_t        word_data,      // oldest queued word
	input  wire                   rd_request,     // one-cycle pop from the writer
	output logic                  overflow        // sticky, word lost to a full queue
);
	import acq_pkg::*;

	//////////////////////////////
	// word assembly
	//////////////////////////////
	logic [3:0] slot_q;      // next slot to fill
	word_t      shift_q;     // partial word, newest sample enters at the top
	word_t      word_next;   // full word once the last slot is taken
	logic       word_done;   // 16th sample of a word arrives this cycle

	assign word_next = {sample, shift_q[word_width-1:sample_width]};   // oldest ends in low bits
	assign word_done = sample_valid && (slot_q == 4'(samples_per_word - 1));

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			slot_q <= '0;
		end else if (sample_valid) begin
			slot_q <= slot_q + 4'd1;                                // wraps after slot 15
		end
	end

	always_ff @(posedge avalon_clk) begin
		if (sample_valid) begin
			shift_q <= word_next;
		end
	end

	//////////////////////////////
	// two-word queue
	//////////////////////////////
	word_t      queue_mem [2];   // word storage
	logic       wr_ptr_q;        // slot for the next push
	logic       rd_ptr_q;        // slot of the oldest word
	logic [1:0] count_q;         // words held, 0 to 2
	logic       full;
	logic       pop;
	logic       push;

	assign full = (count_q == 2'd2);
	assign pop  = rd_request && (count_q != 2'd0);               // writer only pops a ready queue
	assign push = word_done && (!full || pop);                    // pop frees a slot the same cycle

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q  <= 2'd0;
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= ~wr_ptr_q;
			end
			if (pop) begin
				rd_ptr_q <= ~rd_ptr_q;
			end
			count_q <= count_q + 2'(push) - 2'(pop);
			if (word_done && !push) begin
				overflow <= 1'b1;                               // word dropped, stays set until reset
			end
		end
	end

	always_ff @(posedge avalon_clk) begin
		if (push) begin
			queue_mem[wr_ptr_q] <= word_next;
		end
	end

	assign word_ready = (count_q != 2'd0);    // high the cycle after the push edge
	assign word_data  = queue_mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- dram_write_ctrl.sv
`default_nettype none

module dram_write_ctrl (
	input  wire                                          avalon_clk,
	input  wire                                          rst_n,
	input  wire  [acq_pkg::num_channels-1:0]             word_ready,        // per channel queue level
	input  wire  acq_pkg::word_t [acq_pkg::num_channels-1:0] word_data,     // oldest word per channel
	output logic [acq_pkg::num_channels-1:0]             rd_request,        // one-hot pop
	input  wire                                          triggered,
	input  wire  acq_pkg::stamp_t                        trigger_stamp,
	output logic                                         mem_write,
	output acq_pkg::addr_t                               mem_address,
	output acq_pkg::word_t                               mem_writedata,
	input  wire                                          mem_waitrequest_n, // high accepts the write
	output logic                                         capture_done
);
	import acq_pkg::*;

	typedef enum logic [1:0] {
		st_idle,    // nothing in service
		st_grant,   // rd_request high, word gets registered at the end
		st_write    // mem_write held until the memory accepts it
	} state_t;

	state_t                  state_q;
	chan_t                   sel_q;                       // channel in service, also round-robin pointer
	chan_t                   pick;                        // next channel from the arbiter
	logic                    found;                       // some queue is ready
	logic                    can_grant;                   // a new service may start this cycle
	logic                    write_done;                  // write accepted this cycle
	stamp_t                  word_cnt_q [num_channels];   // index of the next word per channel
	logic [num_channels-1:0] stop_q;                      // channel has hit its post-trigger limit
	stamp_t                  cur_word;                    // index of the word in service
	stamp_t                  limit;                       // last word index still written
	logic                    keep;                        // write the word or throw it away

	//////////////////////////////
	// round-robin arbiter
	//////////////////////////////
	always_comb begin
		chan_t idx;
		found = 1'b0;
		pick  = sel_q;
		for (int i = 1; i <= num_channels; i++) begin
			idx = sel_q + chan_t'(i);                           // starts right after the last served
			if (!found && word_ready[idx]) begin
				found = 1'b1;
				pick  = idx;
			end
		end
	end

	assign write_done = mem_write && mem_waitrequest_n;
	// no grant in st_grant, the popped queue still shows its old level there
	assign can_grant  = (state_q == st_idle) || ((state_q == st_write) && write_done);

	//////////////////////////////
	// post-trigger limit
	//////////////////////////////
	assign cur_word = word_cnt_q[sel_q];
	assign limit    = (trigger_stamp >> $clog2(samples_per_word)) + stamp_t'(post_trigger_words);
	assign keep     = !stop_q[sel_q] && (!triggered || (cur_word <= limit));

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			state_q    <= st_idle;
			sel_q      <= chan_t'(num_channels - 1);            // channel 0 is served first
			rd_request <= '0;
			mem_write  <= 1'b0;
			stop_q     <= '0;
			for (int i = 0; i < num_channels; i++) begin
				word_cnt_q[i] <= '0;
			end
		end else begin
			rd_request <= '0;                                  // pop lasts one cycle
			if (write_done) begin
				mem_write <= 1'b0;
			end

			case (state_q)
				st_grant: begin
					word_cnt_q[sel_q] <= cur_word + stamp_t'(1);
					if (keep) begin
						mem_write <= 1'b1;                         // rises with the registered word
						state_q   <= st_write;
					end else begin
						stop_q[sel_q] <= 1'b1;                     // word popped and dropped
						state_q       <= st_idle;
					end
				end
				st_write: begin
					if (write_done) begin
						state_q <= st_idle;
					end
				end
				default: begin
				end
			endcase

			if (can_grant && found) begin
				rd_request[pick] <= 1'b1;
				sel_q            <= pick;
				state_q          <= st_grant;                    // overrides the idle step above
			end
		end
	end

	//////////////////////////////
	// write data and ring address
	//////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (state_q == st_grant) begin
			mem_writedata <= word_data[sel_q];                  // registered data select
			mem_address   <= (addr_t'(sel_q) << region_bits) | (addr_t'(cur_word) & region_mask);
		end
	end

	assign capture_done = &stop_q;    // every channel has dropped a word

endmodule

`default_nettype wire

//--- files.f
acq_pkg.sv
channel_packer.sv
trigger_detector.sv
dram_write_ctrl.sv
acq_top.sv
acq_sva.sv
acq_checker.sv
tb_acq.sv

//--- tb_acq.sv
`default_nettype none

module tb_acq;
	import acq_pkg::*;

	localparam int          clk_period      = 4;
	localparam int          reset_cycles    = 8;
	localparam int          quiet_cycles    = 64;                  // idle bus span that ends a test
	localparam int          test_overhead   = reset_cycles + quiet_cycles + 100;
	localparam int          watchdog_margin = 200;
	localparam int          max_tests       = 16;
	localparam logic [31:0] seed            = 32'd78022;

	logic                       avalon_clk = 1'b0;
	logic                       rst_n;
	logic                       sample_valid;
	sample_t [num_channels-1:0] samples;
	sample_t                    threshold;
	logic                       mem_waitrequest_n;
	logic                       test_end;
	logic                       mem_write;
	addr_t                      mem_address;
	word_t                      mem_writedata;
	logic                       triggered;
	stamp_t                     trigger_stamp;
	logic                       capture_done;
	logic [num_channels-1:0]    overflow;

	int                      golden [max_tests][11];   // one row per test line
	int                      num_tests;
	int                      limit_cycles;
	bit                      loaded = 1'b0;
	int                      test_num;
	int                      cur_count;
	int                      cur_spacing;
	int                      spike_idx;
	int                      spike_ch;
	sample_t                 cur_thr;
	logic [7:0]              cur_stall;
	logic                    exp_trig;
	stamp_t                  exp_stamp;
	int                      exp_words;
	logic [num_channels-1:0] exp_ovf;
	logic                    stall_on;                  // stall mask applies while samples flow
	int                      cycle_cnt;
	logic [31:0]             rng;

	//////////////////////////////
	// clock, DUT and checker
	//////////////////////////////
	always #(clk_period / 2) avalon_clk = ~avalon_clk;

	acq_top acq_top_inst (
		.avalon_clk        (avalon_clk),
		.rst_n             (rst_n),
		.sample_valid      (sample_valid),
		.samples           (samples),
		.threshold         (threshold),
		.mem_waitrequest_n (mem_waitrequest_n),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata),
		.triggered         (triggered),
		.trigger_stamp     (trigger_stamp),
		.capture_done      (capture_done),
		.overflow          (overflow)
	);

	acq_checker checker_inst (
		.avalon_clk        (avalon_clk),
		.rst_n             (rst_n),
		.test_end          (test_end),
		.mem_write         (mem_write),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata),
		.mem_waitrequest_n (mem_waitrequest_n),
		.triggered         (triggered),
		.trigger_stamp     (trigger_stamp),
		.capture_done      (capture_done),
		.overflow          (overflow)
	);

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic load_golden();
		int    fd;
		int    n;
		int    f [11];
		string line;
		fd        = $fopen("acq_golden.txt", "r");
		num_tests = 0;
		if (fd != 0) begin
			while (!$feof(fd) && num_tests < max_tests) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin                  // skip column notes
					n = $sscanf(line, "%d %h %d %d %d %d %h %d %h %d %h", f[0], f[1], f[2],
						f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
					if (n == 11) begin
						for (int i = 0; i < 11; i++)
							golden[num_tests][i] = f[i];
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end
		limit_cycles = watchdog_margin;
		for (int t = 0; t < num_tests; t++)
			limit_cycles += golden[t][2] * golden[t][5] + test_overhead;   // samples x spacing
		loaded = 1'b1;
	endtask

	// one rising edge, all DUT inputs driven here
	task automatic step_cycle(input logic valid, input sample_t [num_channels-1:0] vec,
		input logic pulse);
		@(posedge avalon_clk);
		sample_valid      <= valid;
		samples           <= vec;
		test_end          <= pulse;
		mem_waitrequest_n <= stall_on ? cur_stall[cycle_cnt % 8] : 1'b1;
		cycle_cnt++;
	endtask

	task automatic send_samples();
		sample_t [num_channels-1:0] vec;
		for (int n = 0; n < cur_count; n++) begin
			for (int ch = 0; ch < num_channels; ch++) begin
				rng     = next_rand(rng);
				vec[ch] = rng[15:0] & cur_thr;                      // never above threshold
				if (n == spike_idx && ch == spike_ch)
					vec[ch] = '1;
			end
			step_cycle(1'b1, vec, 1'b0);
			for (int k = 1; k < cur_spacing; k++)
				step_cycle(1'b0, vec, 1'b0);
		end
	endtask

	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < quiet_cycles) begin
			step_cycle(1'b0, '0, 1'b0);
			@(negedge avalon_clk);
			if (mem_write)
				quiet = 0;
			else
				quiet++;
		end
	endtask

	task automatic run_test(input int t);
		test_num    = golden[t][0];
		cur_thr     = sample_t'(golden[t][1]);
		cur_count   = golden[t][2];
		spike_idx   = golden[t][3];
		spike_ch    = golden[t][4];
		cur_spacing = golden[t][5];
		cur_stall   = golden[t][6][7:0];
		exp_trig    = (golden[t][7] != 0);
		exp_stamp   = stamp_t'(golden[t][8]);
		exp_words   = golden[t][9];
		exp_ovf     = golden[t][10][num_channels-1:0];
		threshold   <= cur_thr;
		rst_n       <= 1'b0;
		repeat (reset_cycles) step_cycle(1'b0, '0, 1'b0);
		rst_n       <= 1'b1;
		stall_on    = 1'b1;
		send_samples();
		stall_on    = 1'b0;                                        // memory drains freely
		wait_quiet();
		step_cycle(1'b0, '0, 1'b1);
		step_cycle(1'b0, '0, 1'b0);
		step_cycle(1'b0, '0, 1'b0);
	endtask

	//////////////////////////////
	// watchdog and main sequence
	//////////////////////////////
	initial begin
		wait (loaded);
		repeat (limit_cycles) @(posedge avalon_clk);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst_n             = 1'b0;
		sample_valid      = 1'b0;
		samples           = '0;
		threshold         = '0;
		mem_waitrequest_n = 1'b1;
		test_end          = 1'b0;
		stall_on          = 1'b0;
		cycle_cnt         = 0;
		cur_stall         = 8'hff;
		rng               = seed;
		load_golden();
		if (num_tests == 0) begin
			$display("no test lines could be read from acq_golden.txt");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			step_cycle(1'b0, '0, 1'b0);
			for (int t = 0; t < num_tests; t++)
				run_test(t);
			$display("tests run %0d, failed %0d, errors %0d", checker_inst.tests_done,
				checker_inst.tests_failed, checker_inst.error_count);
			if (checker_inst.error_count == 0 && checker_inst.tests_done == num_tests) begin
				$display("PASS: all tests");
			end else begin
				$display("FAIL: see errors above");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- trigger_detector.sv
`default_nettype none

module trigger_detector (
	input  wire                                            avalon_clk,
	input  wire                                            rst_n,
	input  wire                                            sample_valid,
	input  wire acq_pkg::sample_t [acq_pkg::num_channels-1:0] samples,   // channel 0 in low bits
	input  wire acq_pkg::sample_t                          threshold,      // static during a run
	output logic                                           triggered,      // sticky until reset
	output acq_pkg::stamp_t                                trigger_stamp   // index of first crossing
);
	import acq_pkg::*;

	stamp_t                  stamp_q;   // index of the sample on the inputs now
	logic [num_channels-1:0] above;     // per channel compare result
	logic                    hit;       // valid sample over threshold on any channel
	logic                    first_hit; // the crossing that sets the trigger

	//////////////////////////////
	// parallel threshold compare
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < num_channels; i++) begin
			above[i] = (samples[i] > threshold);                // strictly above as unsigned
		end
	end

	assign hit       = sample_valid && (|above);
	assign first_hit = hit && !triggered;   // later crossings are ignored

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			stamp_q   <= '0;
			triggered <= 1'b0;
		end else begin
			if (sample_valid) begin
				stamp_q <= stamp_q + stamp_t'(1);               // counts valid cycles only
			end
			if (first_hit) begin
				triggered <= 1'b1;
			end
		end
	end

	// stamp of the first crossing held until the next one after reset
	always_ff @(posedge avalon_clk) begin
		if (first_hit) begin
			trigger_stamp <= stamp_q;
		end
	end

endmodule

`default_nettype wire
